/* rtl/rewardPkg.sv */
package rewardPkg;

    // one protocol word shared by ids, hop counts, energy and q values
    localparam int WORD_WIDTH = 16;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // over-the-air packet type codes
    typedef enum logic [2:0] {
        // heartbeat flooded out from the sink
        PKT_HB      = 3'b000,
        // cluster-head election, received only
        PKT_CHE     = 3'b001,
        // invitation from a cluster head
        PKT_INV     = 3'b010,
        // membership request to a cluster head
        PKT_MR      = 3'b011,
        // cluster-head timeslot announcement
        PKT_CHT     = 3'b100,
        PKT_DATA    = 3'b101,
        // data sent by a node low on energy
        PKT_SOS     = 3'b110,
        PKT_INVALID = 3'b111
    } pktType_t;

    // job picked for one packet build
    typedef enum logic [2:0] {
        JOB_HB_RIPPLE    = 3'd0,
        JOB_INV_RIPPLE   = 3'd1,
        JOB_CH_INVITE    = 3'd2,
        JOB_MEMBER_REQ   = 3'd3,
        JOB_CH_TIMESLOT  = 3'd4,
        JOB_DATA_FORWARD = 3'd5,
        JOB_DATA_ORIGIN  = 3'd6,
        JOB_NONE         = 3'd7
    } jobKind_t;

    // invitations stop rippling at this many hops from the cluster head
    localparam word_t INV_HOP_LIMIT = word_t'(4);

    // idle cycles before a cluster timeout fires
    localparam word_t TIMEOUT_RELOAD = word_t'(10);

    // destination for a node one hop from the sink
    localparam word_t SINK_ID = '0;

    // broadcast destination
    localparam word_t BROADCAST_ID = '1;

    // unused field markers
    localparam word_t NO_HOPS = '1;
    localparam word_t NO_CH = '0;

endpackage

/* rtl/jobClassifier.sv */
`timescale 1ns/1ps

module jobClassifier
    import rewardPkg::*;
(
    input  logic     en,
    input  logic     expired,
    input  logic     hbLock,
    input  logic     role,
    input  logic     iAmDestination,
    input  logic     iHaveData,
    input  pktType_t fPacketType,
    input  word_t    fHopsFromCH,
    output logic     jobValid,
    output jobKind_t jobKind
);

    // packet-kind flags from the received fields
    logic isHeartbeat;
    logic isInvite;
    logic isData;
    logic inviteInRange;

    assign isHeartbeat = (fPacketType == PKT_HB);
    assign isInvite = (fPacketType == PKT_INV);
    assign isData = (fPacketType == PKT_DATA) || (fPacketType == PKT_SOS);

    // invitation still inside the ripple radius
    assign inviteInRange = (fHopsFromCH < INV_HOP_LIMIT);

    // a strobe always starts a job even when it builds nothing
    assign jobValid = en | expired;

    always_comb begin
        jobKind = JOB_NONE;
        if (en) begin
            // received packet wins over a pending timeout
            if (isHeartbeat && !hbLock) begin
                // first heartbeat only
                jobKind = JOB_HB_RIPPLE;
            end else if (isInvite && inviteInRange) begin
                jobKind = JOB_INV_RIPPLE;
            end else if (isData && iAmDestination) begin
                // pass on data addressed to us
                jobKind = JOB_DATA_FORWARD;
            end else if (iHaveData) begin
                // own sensor data ready
                jobKind = JOB_DATA_ORIGIN;
            end else if (role) begin
                // cluster head sends its own invitation
                jobKind = JOB_CH_INVITE;
            end else begin
                jobKind = JOB_NONE;
            end
        end else if (expired) begin
            // timeout job depends on role
            if (role) begin
                jobKind = JOB_CH_TIMESLOT;
            end else begin
                jobKind = JOB_MEMBER_REQ;
            end
        end
    end

endmodule

/* rtl/clusterTimer.sv */
`timescale 1ns/1ps

module clusterTimer
    import rewardPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     en,
    input  pktType_t fPacketType,
    input  logic     busy,
    input  logic     jobStart,
    output logic     expired,
    output logic     hbLock
);

    // cluster timeout counter of idle cycles
    word_t count;

    // count only runs once the network has been flooded
    logic countEn;

    // heartbeat lock
    // set by the first heartbeat, released by a data packet
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hbLock <= 1'b0;
        end else if (en) begin
            if (fPacketType == PKT_HB) begin
                hbLock <= 1'b1;
            end else if (fPacketType == PKT_DATA) begin
                hbLock <= 1'b0;
            end
        end
    end

    // freeze while a build is in flight or before any heartbeat
    assign countEn = !busy && hbLock && (count != '0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= TIMEOUT_RELOAD;
        end else if (jobStart) begin
            // any job restarts the wait
            count <= TIMEOUT_RELOAD;
        end else if (countEn) begin
            count <= count - word_t'(1);
        end
    end

    // level that holds at zero until a job reloads the count
    assign expired = (count == '0);

endmodule

/* rtl/rewardSequencer.sv */
`timescale 1ns/1ps

module rewardSequencer
    import rewardPkg::*;
(
    input  logic clk,
    input  logic nrst,
    input  logic jobValid,
    output logic jobStart,
    output logic busy,
    output logic rewardDone
);

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_PROCESS = 2'd1,
        S_DONE    = 2'd2
    } seqState_t;

    seqState_t state;
    seqState_t nextState;

    // only an idle block accepts a job
    // anything arriving later is dropped
    assign jobStart = (state == S_IDLE) && jobValid;

    always_comb begin
        nextState = state;
        case (state)
            S_IDLE: begin
                if (jobValid) begin
                    nextState = S_PROCESS;
                end
            end
            // fields are registered during this cycle
            S_PROCESS: nextState = S_DONE;
            S_DONE: nextState = S_IDLE;
            default: nextState = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= S_IDLE;
        end else begin
            state <= nextState;
        end
    end

    assign busy = (state != S_IDLE);
    // one-cycle pulse two edges after the job starts
    assign rewardDone = (state == S_DONE);

endmodule

/* rtl/packetBuilder.sv */
`timescale 1ns/1ps

module packetBuilder
    import rewardPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     jobStart,
    input  jobKind_t jobKind,
    input  logic     lowE,
    // own node state
    input  word_t    myEnergy,
    input  word_t    myNodeID,
    input  word_t    hopsFromSink,
    input  word_t    myQValue,
    // received packet fields
    input  word_t    fSourceID,
    input  word_t    fSourceHops,
    input  word_t    fQValue,
    input  word_t    fEnergyLeft,
    input  word_t    fHopsFromCH,
    input  word_t    fChosenCH,
    // clustering and routing state
    input  word_t    chosenCH,
    input  word_t    hopsFromCH,
    input  word_t    chosenHop,
    // outgoing packet
    output word_t    rSourceID,
    output word_t    rEnergyLeft,
    output word_t    rQValue,
    output word_t    rSourceHops,
    output word_t    rDestinationID,
    output word_t    rChosenCH,
    output word_t    rHopsFromCH,
    output pktType_t rPacketType
);

    // next packet, decoded from the job
    pktType_t nextType;
    word_t    nextSourceID;
    word_t    nextEnergy;
    word_t    nextQValue;
    word_t    nextSourceHops;
    word_t    nextDestination;
    word_t    nextChosenCH;
    word_t    nextHopsFromCH;

    // next-hop rule shared by both data jobs
    logic     sinkNeighbor;
    word_t    nextHop;
    pktType_t dataType;

    assign sinkNeighbor = (hopsFromSink == word_t'(1));
    assign nextHop = sinkNeighbor ? SINK_ID : chosenHop;
    assign dataType = lowE ? PKT_SOS : PKT_DATA;

    always_comb begin
        // own identity, broadcast, no cluster info
        nextType = PKT_INVALID;
        nextSourceID = myNodeID;
        nextSourceHops = hopsFromSink;
        nextQValue = myQValue;
        nextEnergy = myEnergy;
        nextDestination = BROADCAST_ID;
        nextChosenCH = NO_CH;
        nextHopsFromCH = NO_HOPS;
        case (jobKind)
            JOB_HB_RIPPLE: begin
                // keep the sink as origin, add our hop
                nextType = PKT_HB;
                nextSourceID = fSourceID;
                nextSourceHops = hopsFromSink + word_t'(1);
            end
            JOB_INV_RIPPLE: begin
                // carry the cluster head's identity one hop further
                nextType = PKT_INV;
                nextSourceID = fSourceID;
                nextQValue = fQValue;
                nextEnergy = fEnergyLeft;
                nextHopsFromCH = fHopsFromCH + word_t'(1);
            end
            JOB_CH_INVITE: begin
                nextType = PKT_INV;
                nextHopsFromCH = word_t'(1);
            end
            JOB_MEMBER_REQ: begin
                // unicast to the chosen head
                nextType = PKT_MR;
                nextDestination = chosenCH;
                nextChosenCH = chosenCH;
                nextHopsFromCH = hopsFromCH;
            end
            JOB_CH_TIMESLOT: begin
                nextType = PKT_CHT;
            end
            JOB_DATA_FORWARD: begin
                // payload kept as received and only the route changes
                nextType = dataType;
                nextSourceID = fSourceID;
                nextSourceHops = fSourceHops;
                nextQValue = fQValue;
                nextEnergy = fEnergyLeft;
                nextHopsFromCH = fHopsFromCH;
                nextChosenCH = fChosenCH;
                nextDestination = nextHop;
            end
            JOB_DATA_ORIGIN: begin
                nextType = dataType;
                nextHopsFromCH = hopsFromCH;
                // sink neighbors report straight to the sink
                nextChosenCH = sinkNeighbor ? NO_CH : chosenCH;
                nextDestination = nextHop;
            end
            default: begin
                nextType = PKT_INVALID;
            end
        endcase
    end

    // fields hold from one job to the next
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rPacketType <= PKT_INVALID;
            rSourceID <= '1;
            rDestinationID <= '1;
            rHopsFromCH <= '1;
            rSourceHops <= '1;
            rChosenCH <= '0;
            rQValue <= '0;
            rEnergyLeft <= '0;
        end else if (jobStart) begin
            rPacketType <= nextType;
            rSourceID <= nextSourceID;
            rDestinationID <= nextDestination;
            rHopsFromCH <= nextHopsFromCH;
            rSourceHops <= nextSourceHops;
            rChosenCH <= nextChosenCH;
            rQValue <= nextQValue;
            rEnergyLeft <= nextEnergy;
        end
    end

endmodule

/* rtl/rewardTop.sv */
`timescale 1ns/1ps

module rewardTop
    import rewardPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     en,
    // own node state
    input  word_t    myEnergy,
    input  word_t    myNodeID,
    input  word_t    hopsFromSink,
    input  word_t    myQValue,
    input  logic     role,
    input  logic     lowE,
    input  logic     iHaveData,
    // from the packet filter
    input  logic     iAmDestination,
    // received packet fields
    input  pktType_t fPacketType,
    input  word_t    fSourceID,
    input  word_t    fSourceHops,
    input  word_t    fQValue,
    input  word_t    fEnergyLeft,
    input  word_t    fHopsFromCH,
    input  word_t    fChosenCH,
    // clustering and routing state
    input  word_t    chosenCH,
    input  word_t    hopsFromCH,
    input  word_t    chosenHop,
    // outgoing packet
    output word_t    rSourceID,
    output word_t    rEnergyLeft,
    output word_t    rQValue,
    output word_t    rSourceHops,
    output word_t    rDestinationID,
    output word_t    rChosenCH,
    output word_t    rHopsFromCH,
    output pktType_t rPacketType,
    output logic     rewardDone
);

    // classifier to sequencer and builder
    logic     jobValid;
    jobKind_t jobKind;

    // timer state
    logic     expired;
    logic     hbLock;

    // sequencer controls
    logic     jobStart;
    logic     busy;

    jobClassifier u_jobClassifier (
        .en             (en),
        .expired        (expired),
        .hbLock         (hbLock),
        .role           (role),
        .iAmDestination (iAmDestination),
        .iHaveData      (iHaveData),
        .fPacketType    (fPacketType),
        .fHopsFromCH    (fHopsFromCH),
        .jobValid       (jobValid),
        .jobKind        (jobKind)
    );

    clusterTimer u_clusterTimer (
        .clk         (clk),
        .nrst        (nrst),
        .en          (en),
        .fPacketType (fPacketType),
        .busy        (busy),
        .jobStart    (jobStart),
        .expired     (expired),
        .hbLock      (hbLock)
    );

    rewardSequencer u_rewardSequencer (
        .clk        (clk),
        .nrst       (nrst),
        .jobValid   (jobValid),
        .jobStart   (jobStart),
        .busy       (busy),
        .rewardDone (rewardDone)
    );

    packetBuilder u_packetBuilder (
        .clk            (clk),
        .nrst           (nrst),
        .jobStart       (jobStart),
        .jobKind        (jobKind),
        .lowE           (lowE),
        .myEnergy       (myEnergy),
        .myNodeID       (myNodeID),
        .hopsFromSink   (hopsFromSink),
        .myQValue       (myQValue),
        .fSourceID      (fSourceID),
        .fSourceHops    (fSourceHops),
        .fQValue        (fQValue),
        .fEnergyLeft    (fEnergyLeft),
        .fHopsFromCH    (fHopsFromCH),
        .fChosenCH      (fChosenCH),
        .chosenCH       (chosenCH),
        .hopsFromCH     (hopsFromCH),
        .chosenHop      (chosenHop),
        .rSourceID      (rSourceID),
        .rEnergyLeft    (rEnergyLeft),
        .rQValue        (rQValue),
        .rSourceHops    (rSourceHops),
        .rDestinationID (rDestinationID),
        .rChosenCH      (rChosenCH),
        .rHopsFromCH    (rHopsFromCH),
        .rPacketType    (rPacketType)
    );

endmodule

/* verification/rewardTb.sv */
`timescale 1ns/1ps

module rewardTb
    import rewardPkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS = 5;
    // budget of 200 cycles for every directed test
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * NUM_TESTS;
    localparam int SEED = 32'hbb7cf216;

    logic     clk;
    logic     nrst;
    logic     en;
    word_t    myEnergy;
    word_t    myNodeID;
    word_t    hopsFromSink;
    word_t    myQValue;
    logic     role;
    logic     lowE;
    logic     iHaveData;
    logic     iAmDestination;
    pktType_t fPacketType;
    word_t    fSourceID;
    word_t    fSourceHops;
    word_t    fQValue;
    word_t    fEnergyLeft;
    word_t    fHopsFromCH;
    word_t    fChosenCH;
    word_t    chosenCH;
    word_t    hopsFromCH;
    word_t    chosenHop;
    word_t    rSourceID;
    word_t    rEnergyLeft;
    word_t    rQValue;
    word_t    rSourceHops;
    word_t    rDestinationID;
    word_t    rChosenCH;
    word_t    rHopsFromCH;
    pktType_t rPacketType;
    logic     rewardDone;

    // expected outgoing packet
    pktType_t expType;
    word_t    expSource;
    word_t    expEnergy;
    word_t    expQValue;
    word_t    expHops;
    word_t    expDest;
    word_t    expChosen;
    word_t    expHopsCH;

    rewardTop i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // prints the reason, then the fail line, then stops
    task automatic stopRun(string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(string what, word_t got, word_t exp);
        if (got !== exp) begin
            stopRun($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkType(string what, pktType_t got, pktType_t exp);
        if (got !== exp) begin
            stopRun($sformatf("[ERROR] %0t: %s is %s, expected %s", $time, what,
                got.name(), exp.name()));
        end
    endtask

    task automatic checkDone(string when, logic got, logic exp);
        if (got !== exp) begin
            stopRun($sformatf("[ERROR] %0t: rewardDone is %b %s, expected %b", $time, got,
                when, exp));
        end
    endtask

    function automatic word_t randWord();
        return word_t'($urandom());
    endfunction

    // fresh random fields with all flags low
    task automatic randomizeInputs();
        myEnergy = randWord();
        myNodeID = randWord();
        hopsFromSink = randWord();
        myQValue = randWord();
        fSourceID = randWord();
        fSourceHops = randWord();
        fQValue = randWord();
        fEnergyLeft = randWord();
        fHopsFromCH = randWord();
        fChosenCH = randWord();
        chosenCH = randWord();
        hopsFromCH = randWord();
        chosenHop = randWord();
        role = 1'b0;
        lowE = 1'b0;
        iHaveData = 1'b0;
        iAmDestination = 1'b0;
    endtask

    // reference model of the outgoing packet for a given job
    task automatic predictPacket(jobKind_t kind);
        logic oneHop;
        oneHop = (hopsFromSink == word_t'(1));
        // own identity, broadcast, no cluster fields
        expType = PKT_INVALID;
        expSource = myNodeID;
        expHops = hopsFromSink;
        expQValue = myQValue;
        expEnergy = myEnergy;
        expDest = BROADCAST_ID;
        expChosen = NO_CH;
        expHopsCH = NO_HOPS;
        if (kind == JOB_HB_RIPPLE) begin
            expType = PKT_HB;
            expSource = fSourceID;
            expHops = hopsFromSink + word_t'(1);
        end else if (kind == JOB_INV_RIPPLE) begin
            expType = PKT_INV;
            expSource = fSourceID;
            expQValue = fQValue;
            expEnergy = fEnergyLeft;
            expHopsCH = fHopsFromCH + word_t'(1);
        end else if (kind == JOB_CH_INVITE) begin
            expType = PKT_INV;
            expHopsCH = word_t'(1);
        end else if (kind == JOB_MEMBER_REQ) begin
            expType = PKT_MR;
            expDest = chosenCH;
            expChosen = chosenCH;
            expHopsCH = hopsFromCH;
        end else if (kind == JOB_CH_TIMESLOT) begin
            expType = PKT_CHT;
        end else if (kind == JOB_DATA_FORWARD || kind == JOB_DATA_ORIGIN) begin
            expType = lowE ? PKT_SOS : PKT_DATA;
            // sink neighbors send straight to the sink
            expDest = oneHop ? SINK_ID : chosenHop;
            expHopsCH = (kind == JOB_DATA_ORIGIN) ? hopsFromCH : fHopsFromCH;
            if (kind == JOB_DATA_FORWARD) begin
                expSource = fSourceID;
                expHops = fSourceHops;
                expQValue = fQValue;
                expEnergy = fEnergyLeft;
                expChosen = fChosenCH;
            end else begin
                expChosen = oneHop ? NO_CH : chosenCH;
            end
        end
    endtask

    task automatic checkPacket(string what);
        checkType({what, " type"}, rPacketType, expType);
        checkWord({what, " source"}, rSourceID, expSource);
        checkWord({what, " energy"}, rEnergyLeft, expEnergy);
        checkWord({what, " q value"}, rQValue, expQValue);
        checkWord({what, " hops"}, rSourceHops, expHops);
        checkWord({what, " destination"}, rDestinationID, expDest);
        checkWord({what, " chosen ch"}, rChosenCH, expChosen);
        checkWord({what, " hops from ch"}, rHopsFromCH, expHopsCH);
    endtask

    // one en strobe with the done pulse checked edge by edge
    task automatic runStrobeJob(string what, jobKind_t kind);
        predictPacket(kind);
        @(negedge clk);
        checkDone("before E0", rewardDone, 1'b0);
        en = 1'b1;
        @(negedge clk);
        en = 1'b0;
        checkDone("between E0 and E1", rewardDone, 1'b0);
        // fields valid right after E0
        checkPacket(what);
        @(negedge clk);
        checkDone("between E1 and E2", rewardDone, 1'b1);
        @(negedge clk);
        checkDone("after E2", rewardDone, 1'b0);
        checkPacket(what);
    endtask

    // job started by the cluster timeout without a strobe
    task automatic waitTimeoutJob(string what, jobKind_t kind);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        predictPacket(kind);
        while (!seen && cycles < 3 * int'(TIMEOUT_RELOAD)) begin
            @(negedge clk);
            cycles++;
            if (rewardDone === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            stopRun($sformatf("no done pulse from the cluster timeout for %s", what));
        end else begin
            checkPacket(what);
            @(negedge clk);
            checkDone("after timeout E2", rewardDone, 1'b0);
        end
    endtask

    task automatic resetAndHeartbeat();
        predictPacket(JOB_NONE);
        // reset values differ from the JOB_NONE defaults
        expSource = '1;
        expDest = '1;
        expHopsCH = '1;
        expHops = '1;
        expChosen = '0;
        expQValue = '0;
        expEnergy = '0;
        repeat (5) begin
            @(negedge clk);
            checkDone("after reset", rewardDone, 1'b0);
            checkPacket("reset");
        end
        randomizeInputs();
        fPacketType = PKT_HB;
        runStrobeJob("first heartbeat", JOB_HB_RIPPLE);
        // lock now set so the second one builds nothing
        randomizeInputs();
        runStrobeJob("second heartbeat", JOB_NONE);
        // data packet releases the lock and freezes the timer
        randomizeInputs();
        fPacketType = PKT_DATA;
        runStrobeJob("lock release", JOB_NONE);
    endtask

    task automatic inviteRippleAndLimit();
        randomizeInputs();
        fPacketType = PKT_INV;
        fHopsFromCH = word_t'($urandom_range(0, int'(INV_HOP_LIMIT) - 1));
        runStrobeJob("invite ripple", JOB_INV_RIPPLE);
        randomizeInputs();
        fHopsFromCH = INV_HOP_LIMIT;
        runStrobeJob("invite at limit", JOB_NONE);
        role = 1'b1;
        runStrobeJob("ch invite", JOB_CH_INVITE);
    endtask

    task automatic forwardData();
        for (int e = 0; e < 2; e++) begin
            for (int h = 0; h < 2; h++) begin
                randomizeInputs();
                fPacketType = PKT_DATA;
                iAmDestination = 1'b1;
                lowE = logic'(e);
                hopsFromSink = (h == 0) ? word_t'(1) : word_t'($urandom_range(2, 60));
                runStrobeJob("forward", JOB_DATA_FORWARD);
            end
        end
    endtask

    task automatic originateData();
        for (int h = 0; h < 2; h++) begin
            randomizeInputs();
            // election packet matches no ripple or forward rule
            fPacketType = PKT_CHE;
            iHaveData = 1'b1;
            lowE = logic'($urandom_range(0, 1));
            hopsFromSink = (h == 0) ? word_t'(1) : word_t'($urandom_range(2, 60));
            runStrobeJob("origin", JOB_DATA_ORIGIN);
        end
    endtask

    task automatic clusterTimeoutJobs();
        randomizeInputs();
        fPacketType = PKT_HB;
        runStrobeJob("timer heartbeat", JOB_HB_RIPPLE);
        // en stays low from here on
        randomizeInputs();
        waitTimeoutJob("member request", JOB_MEMBER_REQ);
        role = 1'b1;
        waitTimeoutJob("ch timeslot", JOB_CH_TIMESLOT);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stopRun("timeout: the tests did not finish within the watchdog limit");
    end

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        nrst = 1'b0;
        en = 1'b0;
        fPacketType = PKT_CHE;
        randomizeInputs();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        resetAndHeartbeat();
        inviteRippleAndLimit();
        forwardData();
        originateData();
        clusterTimeoutJobs();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* vlog.f */
rtl/rewardPkg.sv
rtl/jobClassifier.sv
rtl/clusterTimer.sv
rtl/rewardSequencer.sv
rtl/packetBuilder.sv
rtl/rewardTop.sv
verification/rewardTb.sv

/* Bender.yml */
package:
  name: reward_builder

sources:
  - rtl/rewardPkg.sv
  - rtl/jobClassifier.sv
  - rtl/clusterTimer.sv
  - rtl/rewardSequencer.sv
  - rtl/packetBuilder.sv
  - rtl/rewardTop.sv
  - target: test
    files:
      - verification/rewardTb.sv
